/* all.f */
+incdir+hdl
hdl/videoPkg.sv
hdl/cpuBusPkg.sv
hdl/clockPhaseGen.sv
hdl/videoCounters.sv
hdl/controlRegisters.sv
hdl/irqController.sv
hdl/vramAddrMux.sv
hdl/k052109.sv
tb/k052109Tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module k052109Tb -o simv

out=$(./obj_dir/simv)
echo "$out"

if grep -qx "Test OK" <<< "$out"; then
    exit 0
fi
exit 1

/* tb/k052109Tb.sv */
`timescale 1ns/10ps

`include "k052109_params.svh"

module k052109Tb;
    import videoPkg::*;
    import cpuBusPkg::*;

    logic     M24 = 1'b0;
    logic     rstN;
    cpuAddrT  ab;
    cpuDataT  db;
    logic     rdN;
    logic     vcsN;
    logic     m12;
    logic     pe;
    logic     pq;
    logic     irqN;
    logic     firqN;
    logic     nmiN;
    logic     cpuRstN;
    vramAddrT ra;
    logic     roeN;
    logic     rweN;
    logic [2:0] flagsN;                 // Same bit order as irqEn

    phaseT    mPhase;                   // Model phase
    hCountT   mH;                       // Model pixel count
    vCountT   mV;                       // Model line count
    int       mFrames;                  // Vblank lines entered since reset
    logic     mRstRel;                  // Expected cpuRstN
    logic     mFlip;
    logic     phaseEn;                  // Compare enables
    logic     renderEn;
    logic     cpuEn;
    cpuAddrT  expAb;
    logic     expRd;                    // 1 for a CPU read
    logic     timedOut;
    int       errors;
    int       checks;
    int       testStartErr;
    int       testsFailed;

    assign flagsN = {irqN, firqN, nmiN};

    k052109 UUT (.M24(M24), .rstN(rstN), .ab(ab), .db(db), .rdN(rdN), .vcsN(vcsN),
        .m12(m12), .pe(pe), .pq(pq), .irqN(irqN), .firqN(firqN), .nmiN(nmiN),
        .cpuRstN(cpuRstN), .ra(ra), .roeN(roeN), .rweN(rweN));

    always #4 M24 = ~M24;               // 8 ns period

    // ------------------------------------------------------------------------
    // Raster model
    // ------------------------------------------------------------------------
    always @(posedge M24 or negedge rstN) begin : model
        vCountT nv;
        if (!rstN) begin
            mPhase  <= phA;
            mH      <= '0;
            mV      <= '0;
            mFrames <= 0;
            mRstRel <= 1'b0;
        end else begin
            mPhase  <= (mPhase == phD) ? phA : phaseT'(mPhase + 1'b1);
            mRstRel <= mRstRel || (mFrames >= `RST_DELAY_FRAMES);  // One cycle after trigger
            if (mPhase == phD) begin                              // Pixel step
                if (mH == hCountT'(`H_TOTAL - 1)) begin
                    nv = (mV == vCountT'(`V_TOTAL - 1)) ? '0 : mV + 1'b1;
                    mH <= '0;
                    mV <= nv;
                    if (nv == vCountT'(`V_IRQ_LINE))
                        mFrames <= mFrames + 1;
                end else begin
                    mH <= mH + 1'b1;
                end
            end
        end
    end

    // Tile map fetch address from raw counts
    function automatic vramAddrT expRender(hCountT h, vCountT v, logic f);
        hCountT c;
        vCountT r;
        c = f ? ~h : h;
        r = f ? ~v : v;
        return {h[0] ? 2'b10 : 2'b01, r[7:3], c[8:3]};
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic checkAddr(string name, vramAddrT got, vramAddrT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h (line %0d, pixel %0d)",
                name, got, exp, mV, mH);
        end
    endtask

    task automatic checkPhase(phaseT ph, logic gotM12, logic gotPe, logic gotPq);
        logic [2:0] exp;
        exp = {(ph == phB) || (ph == phD), (ph == phC) || (ph == phD),
               (ph == phB) || (ph == phC)};
        checks++;
        if ({gotM12, gotPe, gotPq} !== exp) begin
            errors++;
            $display("FAILED m12/pe/pq: got 0x%h, expected 0x%h in %s",
                {gotM12, gotPe, gotPq}, exp, ph.name());
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic reportError(string msg);
        checks++;
        errors++;
        $display("%s", msg);
    endtask

    // Comparing process, sampled away from the active edge
    always @(negedge M24) begin
        if (phaseEn)
            checkPhase(mPhase, m12, pe, pq);
        if (renderEn && mPhase == phB)
            checkAddr("ra", ra, expRender(mH, mV, mFlip));
        if (cpuEn && mPhase == phD) begin   // Reflects the phC CPU slot
            checkAddr("ra", ra, expAb[12:0]);
            checkFlag("rweN", rweN, expRd);
            checkFlag("roeN", roeN, !expRd);
        end
        checkFlag("cpuRstN", cpuRstN, mRstRel);
    end

    // ------------------------------------------------------------------------
    // Waits, each bounded
    // ------------------------------------------------------------------------
    task automatic waitPhase(phaseT ph);
        int n;
        n = 0;
        @(negedge M24);
        while (mPhase != ph && !timedOut) begin
            if (n > 8) begin
                timedOut = 1'b1;
                reportError($sformatf("Timed out waiting for phase %s", ph.name()));
            end
            @(negedge M24);
            n++;
        end
    endtask

    task automatic waitLines(int lines);
        int     seen;
        int     n;
        vCountT last;
        seen = 0;
        n    = 0;
        last = mV;
        while (seen < lines && !timedOut) begin
            @(negedge M24);
            n++;
            if (mV != last) begin
                seen++;
                last = mV;
            end
            if (n > lines * `H_TOTAL * 4 + 16) begin
                timedOut = 1'b1;
                reportError("Timed out waiting for the line count to advance");
            end
        end
    endtask

    task automatic waitFlagHigh(int idx);
        int n;
        n = 0;
        while (!flagsN[idx] && !timedOut) begin
            @(negedge M24);
            n++;
            if (n > 16) begin
                timedOut = 1'b1;
                reportError($sformatf("Interrupt flag %0d did not return high", idx));
            end
        end
    endtask

    // Register write held for one E period
    task automatic writeReg(cpuAddrT addr, cpuDataT data);
        waitPhase(phA);
        ab   = addr;
        db   = data;
        rdN  = 1'b1;
        vcsN = 1'b0;
        waitPhase(phD);
        waitPhase(phA);                 // Written on the edge leaving phD
        vcsN = 1'b1;
    endtask

    task automatic endTest(string name);
        if (errors == testStartErr) begin
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errors - testStartErr);
        end
        testStartErr = errors;
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] rnd;
        int          fallLine [3];
        int          n;
        logic [2:0]  en;
        rnd = $urandom(32'h8dc0);       // Seed once
        ab = '0;
        db = '0;
        rdN = 1'b1;
        vcsN = 1'b1;
        rstN = 1'b0;
        mFlip = 1'b0;
        phaseEn = 1'b0;
        renderEn = 1'b0;
        cpuEn = 1'b0;
        expAb = '0;
        expRd = 1'b0;
        timedOut = 1'b0;
        errors = 0;
        checks = 0;
        testStartErr = 0;
        testsFailed = 0;

        // Reset and phase table
        repeat (10) @(negedge M24);
        checkFlag("roeN", roeN, 1'b1);
        checkFlag("rweN", rweN, 1'b1);
        for (int i = 0; i < 3; i++)
            checkFlag($sformatf("flagsN[%0d]", i), flagsN[i], 1'b1);
        rstN = 1'b1;
        @(negedge M24);
        checkFlag("roeN", roeN, 1'b0);  // Tile fetch starts on the first edge
        checkFlag("rweN", rweN, 1'b1);
        for (int i = 0; i < 3; i++)
            checkFlag($sformatf("flagsN[%0d]", i), flagsN[i], 1'b1);
        phaseEn <= 1'b1;
        repeat (64) @(negedge M24);
        phaseEn <= 1'b0;
        endTest("reset and phase");

        renderEn <= 1'b1;
        waitLines(3);
        renderEn <= 1'b0;
        endTest("render address");

        writeReg(`AB_BITS'(`REG_FLIP_ADDR), 8'h01);
        mFlip    <= 1'b1;
        renderEn <= 1'b1;
        waitLines(2);
        renderEn <= 1'b0;
        writeReg(`AB_BITS'(`REG_FLIP_ADDR), 8'h00);
        mFlip    <= 1'b0;
        endTest("flip");

        // Random CPU slot accesses, register addresses skipped
        for (int k = 0; k < 40; k++) begin
            waitPhase(phA);
            rnd = $urandom;
            while (rnd[12:0] == `REG_IRQ_EN_ADDR || rnd[12:0] == `REG_FLIP_ADDR)
                rnd = $urandom;
            ab    = rnd[15:0];
            rdN   = !rnd[16];
            vcsN  = 1'b0;
            expAb <= rnd[15:0];
            expRd <= rnd[16];
            cpuEn <= 1'b1;
        end
        waitPhase(phD);
        waitPhase(phA);
        vcsN  = 1'b1;
        rdN   = 1'b1;
        cpuEn <= 1'b0;
        endTest("cpu access");

        writeReg(`AB_BITS'(`REG_IRQ_EN_ADDR), 8'h07);
        fallLine = '{-1, -1, -1};
        n = 0;
        while (flagsN != 3'b000 && !timedOut) begin
            @(negedge M24);
            n++;
            for (int i = 0; i < 3; i++)
                if (!flagsN[i] && fallLine[i] < 0)
                    fallLine[i] = mV;
            if (n > `V_TOTAL * `H_TOTAL * 4 + 16) begin
                timedOut = 1'b1;
                reportError("Timed out waiting for all interrupt flags to fall");
            end
        end
        if (fallLine[2] != `V_IRQ_LINE)
            reportError($sformatf("irqN fell on line %0d, not the vblank line", fallLine[2]));
        if (fallLine[1] % 2 != 1)
            reportError($sformatf("firqN fell on even line %0d", fallLine[1]));
        if (fallLine[0] % `NMI_LINE_PERIOD != 0)
            reportError($sformatf("nmiN fell on line %0d, not a multiple of 32", fallLine[0]));
        for (int i = 0; i < 3; i++) begin   // Disable NMI, then FIRQ, then IRQ
            en = 3'b111 << (i + 1);
            writeReg(`AB_BITS'(`REG_IRQ_EN_ADDR), {5'b0, en});
            waitFlagHigh(i);
            for (int j = 0; j < 3; j++)     // Enabled flags stay latched low
                checkFlag($sformatf("flagsN[%0d]", j), flagsN[j], !en[j]);
        end
        endTest("interrupts");

        n = 0;
        while (!cpuRstN && !timedOut) begin
            @(negedge M24);
            n++;
            if (n > (`RST_DELAY_FRAMES + 1) * `V_TOTAL * `H_TOTAL * 4) begin
                timedOut = 1'b1;
                reportError("Timed out waiting for the CPU reset release");
            end
        end
        if (mFrames != `RST_DELAY_FRAMES)
            reportError($sformatf("cpuRstN rose after %0d frames", mFrames));
        waitLines(`V_TOTAL);            // Must stay high for a further frame
        endTest("reset release");

        $display("Summary: 6 tests, %0d failed, %0d checks, %0d errors",
            testsFailed, checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* hdl/k052109.sv */
`timescale 1ns/10ps

module k052109 (
    input  logic               M24,
    input  logic               rstN,
    input  cpuBusPkg::cpuAddrT ab,
    input  cpuBusPkg::cpuDataT db,
    input  logic               rdN,      // High for write
    input  logic               vcsN,     // VRAM and register select
    output logic               m12,
    output logic               pe,
    output logic               pq,
    output logic               irqN,
    output logic               firqN,
    output logic               nmiN,
    output logic               cpuRstN,
    output videoPkg::vramAddrT ra,
    output logic               roeN,
    output logic               rweN
);
    import videoPkg::*;
    import cpuBusPkg::*;

    logic   pxStep;                     // Pixel clock enable
    logic   flip;
    irqEnT  irqEn;
    hCountT col;
    vCountT row;
    layerT  layer;
    logic   irqTrig;
    logic   firqTrig;
    logic   nmiTrig;

    // ------------------------------------------------------------------------
    // Timing and raster
    // ------------------------------------------------------------------------
    clockPhaseGen uClk (.M24(M24), .rstN(rstN), .m12(m12), .pe(pe), .pq(pq), .pxStep(pxStep));

    videoCounters uCnt (.M24(M24), .rstN(rstN), .pxStep(pxStep), .flip(flip), .col(col),
        .row(row), .layer(layer), .irqTrig(irqTrig), .firqTrig(firqTrig), .nmiTrig(nmiTrig));

    // ------------------------------------------------------------------------
    // CPU side
    // ------------------------------------------------------------------------
    controlRegisters uRegs (.M24(M24), .rstN(rstN), .pxStep(pxStep), .ab(ab), .db(db),
        .rdN(rdN), .vcsN(vcsN), .irqEn(irqEn), .flip(flip));

    irqController uIrq (.M24(M24), .rstN(rstN), .irqEn(irqEn), .irqTrig(irqTrig),
        .firqTrig(firqTrig), .nmiTrig(nmiTrig), .irqN(irqN), .firqN(firqN), .nmiN(nmiN),
        .cpuRstN(cpuRstN));

    vramAddrMux uMux (.M24(M24), .rstN(rstN), .pe(pe), .ab(ab), .rdN(rdN), .vcsN(vcsN),
        .col(col), .row(row), .layer(layer), .ra(ra), .roeN(roeN), .rweN(rweN));

endmodule

/* hdl/vramAddrMux.sv */
`timescale 1ns/10ps

`include "k052109_params.svh"

module vramAddrMux (
    input  logic               M24,
    input  logic               rstN,
    input  logic               pe,      // High marks CPU slot
    input  cpuBusPkg::cpuAddrT ab,
    input  logic               rdN,
    input  logic               vcsN,
    input  videoPkg::hCountT   col,
    input  videoPkg::vCountT   row,
    input  videoPkg::layerT    layer,
    output videoPkg::vramAddrT ra,
    output logic               roeN,
    output logic               rweN
);
    import videoPkg::*;

    logic     cpuSlot;
    vramAddrT renderAddr;

    assign cpuSlot = pe && !vcsN;
    // Map page, 32 tile rows, 64 tile columns
    assign renderAddr = {(layer == layerA) ? 2'b01 : 2'b10, row[7:3], col[8:3]};

    always_ff @(posedge M24) begin
        ra <= cpuSlot ? ab[`RA_BITS-1:0] : renderAddr;
    end

    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            roeN <= 1'b1;
            rweN <= 1'b1;
        end else begin
            roeN <= cpuSlot && rdN;     // Low for CPU reads and tile fetch
            rweN <= !(cpuSlot && rdN);  // Low only for CPU writes
        end
    end

    // Write strobe starts only in the E high window
    assert property (@(posedge M24) disable iff (!rstN) $fell(rweN) |-> pe);

endmodule

/* hdl/irqController.sv */
`timescale 1ns/10ps

`include "k052109_params.svh"

module irqController (
    input  logic             M24,
    input  logic             rstN,
    input  cpuBusPkg::irqEnT irqEn,
    input  logic             irqTrig,
    input  logic             firqTrig,
    input  logic             nmiTrig,
    output logic             irqN,
    output logic             firqN,
    output logic             nmiN,
    output logic             cpuRstN   // Delayed CPU reset release
);
    localparam int CntBits = $clog2(`RST_DELAY_FRAMES + 1);

    logic [2:0]         trigVec;        // Same bit order as irqEn
    logic [2:0]         flagN;
    logic [CntBits-1:0] frameCnt;       // Vblank triggers seen so far

    assign trigVec = {irqTrig, firqTrig, nmiTrig};

    // Disabled flag is held high, enabled one latches its trigger
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            flagN <= '1;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (!irqEn[i])
                    flagN[i] <= 1'b1;
                else if (trigVec[i])
                    flagN[i] <= 1'b0;
            end
        end
    end

    assign {irqN, firqN, nmiN} = flagN;

    // Frame count runs regardless of IRQ enable
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            frameCnt <= '0;
            cpuRstN  <= 1'b0;
        end else if (irqTrig && !cpuRstN) begin
            frameCnt <= frameCnt + 1'b1;
            if (frameCnt == CntBits'(`RST_DELAY_FRAMES - 1))
                cpuRstN <= 1'b1;        // Sticky until next core reset
        end
    end

    assert property (@(posedge M24) disable iff (!rstN) !$fell(cpuRstN));

endmodule

/* hdl/controlRegisters.sv */
`timescale 1ns/10ps

`include "k052109_params.svh"

module controlRegisters (
    input  logic               M24,
    input  logic               rstN,
    input  logic               pxStep,  // Write sample point
    input  cpuBusPkg::cpuAddrT ab,
    input  cpuBusPkg::cpuDataT db,
    input  logic               rdN,     // High for CPU write
    input  logic               vcsN,
    output cpuBusPkg::irqEnT   irqEn,
    output logic               flip
);
    import cpuBusPkg::*;

    regSelT regSel;
    logic   wrStb;

    assign wrStb = pxStep && !vcsN && rdN;

    // Register decode on low address bits
    always_comb begin
        case (ab[12:0])
            `REG_IRQ_EN_ADDR: regSel = regIrqEn;
            `REG_FLIP_ADDR:   regSel = regFlip;
            default:          regSel = regNone;
        endcase
    end

    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            irqEn <= '0;
            flip  <= 1'b0;
        end else if (wrStb) begin
            case (regSel)
                regIrqEn: irqEn <= db[2:0];  // IRQ, FIRQ, NMI enables
                regFlip:  flip  <= db[0];
                default:  ;                  // Other VRAM writes ignored
            endcase
        end
    end

endmodule

/* hdl/videoCounters.sv */
`timescale 1ns/10ps

`include "k052109_params.svh"

module videoCounters (
    input  logic             M24,
    input  logic             rstN,
    input  logic             pxStep,
    input  logic             flip,     // Screen flip register
    output videoPkg::hCountT col,      // Flipped pixel count
    output videoPkg::vCountT row,      // Flipped line count
    output videoPkg::layerT  layer,    // Layer of current fetch
    output logic             irqTrig,  // Entering vblank line
    output logic             firqTrig, // Entering odd line
    output logic             nmiTrig   // Entering every 32nd line
);
    import videoPkg::*;

    hCountT hCount;
    vCountT vCount;
    vCountT vNext;                      // Line that follows vCount
    logic   lineEnd;

    assign lineEnd = (hCount == hCountT'(`H_TOTAL - 1));
    assign vNext   = (vCount == vCountT'(`V_TOTAL - 1)) ? '0 : vCount + 1'b1;

    // ------------------------------------------------------------------------
    // Raster counters and line entry triggers
    // ------------------------------------------------------------------------
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            hCount   <= '0;
            vCount   <= '0;
            irqTrig  <= 1'b0;
            firqTrig <= 1'b0;
            nmiTrig  <= 1'b0;
        end else begin
            irqTrig  <= 1'b0;          // Pulses last one M24 cycle
            firqTrig <= 1'b0;
            nmiTrig  <= 1'b0;
            if (pxStep) begin
                if (lineEnd) begin
                    hCount   <= '0;
                    vCount   <= vNext;
                    irqTrig  <= (vNext == vCountT'(`V_IRQ_LINE));
                    firqTrig <= vNext[0];
                    nmiTrig  <= ((vNext & vCountT'(`NMI_LINE_PERIOD - 1)) == '0);
                end else begin
                    hCount <= hCount + 1'b1;
                end
            end
        end
    end

    // Flip mirrors both axes
    assign col   = hCount ^ {`H_BITS{flip}};
    assign row   = vCount ^ {`V_BITS{flip}};
    assign layer = hCount[0] ? layerB : layerA;  // Layers interleave per step

    // Line count moves only across a line wrap
    assert property (@(posedge M24) disable iff (!rstN)
        $changed(vCount) |-> (hCount == '0) && ($past(hCount) == hCountT'(`H_TOTAL - 1)));

endmodule

/* hdl/clockPhaseGen.sv */
`timescale 1ns/10ps

module clockPhaseGen (
    input  logic M24,
    input  logic rstN,
    output logic m12,                   // Half rate CPU master clock
    output logic pe,                    // E clock, high in CPU slot
    output logic pq,                    // Q clock, leads E by 90 degrees
    output logic pxStep                 // Single cycle pulse in phD
);
    import videoPkg::*;

    phaseT phase;
    phaseT phaseNext;

    always_comb begin
        case (phase)
            phA:     phaseNext = phB;
            phB:     phaseNext = phC;
            phC:     phaseNext = phD;
            phD:     phaseNext = phA;
            default: phaseNext = phA;
        endcase
    end

    // Outputs decoded from the next phase so they line up with phase
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            phase  <= phA;
            m12    <= 1'b0;
            pq     <= 1'b0;
            pe     <= 1'b0;
            pxStep <= 1'b0;
        end else begin
            phase  <= phaseNext;
            m12    <= (phaseNext == phB) || (phaseNext == phD);  // Toggles every M24
            pq     <= (phaseNext == phB) || (phaseNext == phC);
            pe     <= (phaseNext == phC) || (phaseNext == phD);
            pxStep <= (phaseNext == phD);
        end
    end

    // E and Q stay in quadrature
    assert property (@(posedge M24) disable iff (!rstN) !($changed(pe) && $changed(pq)));

endmodule

/* hdl/cpuBusPkg.sv */
package cpuBusPkg;

    `include "k052109_params.svh"

    typedef logic [`AB_BITS-1:0] cpuAddrT;  // Full CPU address
    typedef logic [`DB_BITS-1:0] cpuDataT;  // CPU data byte

    // Decoded write target
    typedef enum logic [1:0] {
        regNone,                        // Not a core register
        regIrqEn,                       // 0x1D00
        regFlip                         // 0x1E80
    } regSelT;

    // Bit 0 NMI, bit 1 FIRQ, bit 2 IRQ
    typedef logic [2:0] irqEnT;

endpackage

/* hdl/videoPkg.sv */
package videoPkg;

    `include "k052109_params.svh"

    // Position inside one E period
    typedef enum logic [1:0] {
        phA,                            // All clocks low
        phB,                            // Q rises
        phC,                            // E rises
        phD                             // Q falls, pixel step
    } phaseT;

    typedef logic [`H_BITS-1:0]  hCountT;   // Pixel within line
    typedef logic [`V_BITS-1:0]  vCountT;   // Line within frame

    // Tile map layer under fetch
    typedef enum logic {
        layerA,
        layerB
    } layerT;

    typedef logic [`RA_BITS-1:0] vramAddrT; // VRAM word address

endpackage

/* hdl/k052109_params.svh */
`ifndef K052109_PARAMS_SVH
`define K052109_PARAMS_SVH

// ------------------------------------------------------------------------
// Raster geometry
// ------------------------------------------------------------------------
`define H_TOTAL          384        // Pixels per line
`define V_TOTAL          264        // Lines per frame
`define H_BITS           9          // Horizontal counter width
`define V_BITS           9          // Vertical counter width

// Interrupt trigger lines
`define V_IRQ_LINE       240        // Start of vertical blank
`define NMI_LINE_PERIOD  32         // Must stay a power of two
`define RST_DELAY_FRAMES 8          // Frames before CPU leaves reset

// ------------------------------------------------------------------------
// Bus widths and register map
// ------------------------------------------------------------------------
`define RA_BITS          13         // VRAM address
`define AB_BITS          16         // CPU address
`define DB_BITS          8          // CPU data

`define REG_IRQ_EN_ADDR  13'h1D00   // Interrupt enables, NMI in bit 0
`define REG_FLIP_ADDR    13'h1E80   // Screen flip in bit 0

`endif
